/* source/bmem_pkg.sv */
package bmem_pkg;

    // burst port
    localparam int BMEM_ADDR_W = 32;
    localparam int BMEM_DATA_W = 64;

    // line geometry
    localparam int LINE_W         = 256;
    localparam int BEATS_PER_LINE = LINE_W / BMEM_DATA_W;
    localparam int BEAT_CNT_W     = $clog2(BEATS_PER_LINE);

    // tag bits sit above the byte offset in a line
    localparam int LINE_OFFSET_W = 5;

    typedef enum logic [1:0] {
        fill_idle    = 2'd0,
        fill_request = 2'd1,
        fill_collect = 2'd2,
        fill_done    = 2'd3
    } fill_state_e;

endpackage : bmem_pkg

/* source/fetch_pkg.sv */
package fetch_pkg;

    localparam int PC_W    = 32;
    localparam int INST_W  = 32;
    // sequence number of a fetched instruction
    localparam int ORDER_W = 64;

    localparam logic [PC_W-1:0] RESET_PC = 32'haaaaa000;

    // instruction queue
    localparam int QUEUE_DEPTH = 32;
    localparam int QUEUE_PTR_W = 5;

    // pc bits that pick a word out of a line
    localparam int WORD_SEL_W = 3;

    typedef enum logic [1:0] {
        fetch_run            = 2'd0,
        // fill for the current pc in flight
        fetch_miss_wait      = 2'd1,
        // fill for a stale pc still in flight after a redirect
        fetch_redirect_drain = 2'd2
    } fetch_state_e;

endpackage : fetch_pkg

/* source/line_fill.sv */
`timescale 1ns/10ps

module line_fill (
    input  logic                             clk,
    input  logic                             rst,

    input  logic                             fill_valid_i,
    input  logic [bmem_pkg::BMEM_ADDR_W-1:0] fill_addr_i,
    output logic                             fill_ready_o,

    output logic                             line_valid_o,
    output logic [bmem_pkg::LINE_W-1:0]      line_data_o,
    output logic [bmem_pkg::BMEM_ADDR_W-1:0] line_addr_o,

    output logic [bmem_pkg::BMEM_ADDR_W-1:0] bmem_addr_o,
    output logic                             bmem_read_o,
    input  logic                             bmem_ready_i,
    input  logic [bmem_pkg::BMEM_DATA_W-1:0] bmem_rdata_i,
    input  logic                             bmem_rvalid_i
);

    bmem_pkg::fill_state_e              state_q;
    logic [bmem_pkg::BEAT_CNT_W-1:0]    beat_q;
    logic [bmem_pkg::BMEM_ADDR_W-1:0]   addr_q;
    logic [bmem_pkg::LINE_W-1:0]        line_q;
    logic                               last_beat;

    assign last_beat = (beat_q == bmem_pkg::BEAT_CNT_W'(bmem_pkg::BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= bmem_pkg::fill_idle;
            beat_q  <= '0;
        end else begin
            case (state_q)
                bmem_pkg::fill_idle: begin
                    beat_q <= '0;
                    if (fill_valid_i) begin
                        state_q <= bmem_pkg::fill_request;
                    end
                end
                bmem_pkg::fill_request: begin
                    // read held until the memory takes it
                    if (bmem_ready_i) begin
                        state_q <= bmem_pkg::fill_collect;
                    end
                end
                bmem_pkg::fill_collect: begin
                    if (bmem_rvalid_i) begin
                        beat_q <= beat_q + bmem_pkg::BEAT_CNT_W'(1);
                        if (last_beat) begin
                            state_q <= bmem_pkg::fill_done;
                        end
                    end
                end
                bmem_pkg::fill_done: begin
                    state_q <= bmem_pkg::fill_idle;
                end
                default: begin
                    state_q <= bmem_pkg::fill_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == bmem_pkg::fill_idle && fill_valid_i) begin
            addr_q <= {fill_addr_i[bmem_pkg::BMEM_ADDR_W-1:bmem_pkg::LINE_OFFSET_W],
                       {bmem_pkg::LINE_OFFSET_W{1'b0}}};
        end
        // beats come lowest address first
        if (state_q == bmem_pkg::fill_collect && bmem_rvalid_i) begin
            line_q[beat_q*bmem_pkg::BMEM_DATA_W +: bmem_pkg::BMEM_DATA_W] <= bmem_rdata_i;
        end
    end

    assign fill_ready_o = (state_q == bmem_pkg::fill_idle);
    assign bmem_read_o  = (state_q == bmem_pkg::fill_request);
    assign bmem_addr_o  = addr_q;
    assign line_valid_o = (state_q == bmem_pkg::fill_done);
    assign line_data_o  = line_q;
    assign line_addr_o  = addr_q;

endmodule : line_fill

/* source/line_buffer.sv */
`timescale 1ns/10ps

module line_buffer (
    input  logic                             clk,
    input  logic                             rst,

    input  logic                             line_valid_i,
    input  logic [bmem_pkg::LINE_W-1:0]      line_data_i,
    input  logic [bmem_pkg::BMEM_ADDR_W-1:0] line_addr_i,

    input  logic [fetch_pkg::PC_W-1:0]       pc_i,
    output logic                             hit_o,
    output logic [fetch_pkg::INST_W-1:0]     word_o
);

    logic                                                       valid_q;
    logic [bmem_pkg::BMEM_ADDR_W-1:bmem_pkg::LINE_OFFSET_W]    tag_q;
    logic [bmem_pkg::LINE_W-1:0]                                data_q;
    logic [fetch_pkg::WORD_SEL_W-1:0]                           word_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (line_valid_i) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (line_valid_i) begin
            tag_q  <= line_addr_i[bmem_pkg::BMEM_ADDR_W-1:bmem_pkg::LINE_OFFSET_W];
            data_q <= line_data_i;
        end
    end

    // word index sits just below the line offset boundary
    assign word_sel = pc_i[bmem_pkg::LINE_OFFSET_W-1 -: fetch_pkg::WORD_SEL_W];

    assign hit_o  = valid_q && (pc_i[fetch_pkg::PC_W-1:bmem_pkg::LINE_OFFSET_W] == tag_q);
    assign word_o = data_q[word_sel*fetch_pkg::INST_W +: fetch_pkg::INST_W];

endmodule : line_buffer

/* source/fetch_ctrl.sv */
`timescale 1ns/10ps

module fetch_ctrl (
    input  logic                             clk,
    input  logic                             rst,

    input  logic                             redirect_valid_i,
    input  logic [fetch_pkg::PC_W-1:0]       redirect_pc_i,

    input  logic                             hit_i,
    input  logic [fetch_pkg::INST_W-1:0]     word_i,
    output logic [fetch_pkg::PC_W-1:0]       pc_o,

    output logic                             fill_valid_o,
    output logic [bmem_pkg::BMEM_ADDR_W-1:0] fill_addr_o,
    input  logic                             fill_ready_i,
    input  logic                             line_valid_i,

    output logic                             enq_valid_o,
    output logic [fetch_pkg::PC_W-1:0]       enq_pc_o,
    output logic [fetch_pkg::INST_W-1:0]     enq_inst_o,
    output logic [fetch_pkg::ORDER_W-1:0]    enq_order_o,
    input  logic                             enq_ready_i,

    input  logic                             deq_i,
    output logic                             flush_o
);

    fetch_pkg::fetch_state_e              state_q;
    logic [fetch_pkg::PC_W-1:0]           pc_q;
    logic [fetch_pkg::ORDER_W-1:0]        order_q;
    logic [fetch_pkg::ORDER_W-1:0]        delivered_q;
    logic [fetch_pkg::ORDER_W-1:0]        delivered_next;
    logic                                 fill_valid_q;
    logic [bmem_pkg::BMEM_ADDR_W-1:0]     fill_addr_q;
    logic                                 fill_fire;
    logic                                 enq_fire;
    logic                                 fill_pending;

    assign fill_fire = fill_valid_q && fill_ready_i;
    assign enq_fire  = enq_valid_o && enq_ready_i;

    // a handshake in the redirect cycle still counts for the old stream
    assign delivered_next = deq_i ? delivered_q + fetch_pkg::ORDER_W'(1) : delivered_q;

    // fill still owed to the line buffer once this edge passes
    assign fill_pending = fill_valid_q ||
                          ((state_q != fetch_pkg::fetch_run) && !line_valid_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= fetch_pkg::fetch_run;
            pc_q         <= fetch_pkg::RESET_PC;
            order_q      <= '0;
            delivered_q  <= '0;
            fill_valid_q <= 1'b0;
        end else begin
            delivered_q <= delivered_next;
            if (fill_fire) begin
                fill_valid_q <= 1'b0;
            end
            if (redirect_valid_i) begin
                pc_q    <= redirect_pc_i;
                order_q <= delivered_next;
                state_q <= fill_pending ? fetch_pkg::fetch_redirect_drain : fetch_pkg::fetch_run;
            end else begin
                case (state_q)
                    fetch_pkg::fetch_run: begin
                        if (enq_fire) begin
                            pc_q    <= pc_q + fetch_pkg::PC_W'(4);
                            order_q <= order_q + fetch_pkg::ORDER_W'(1);
                        end else if (!hit_i && !fill_valid_q) begin
                            fill_valid_q <= 1'b1;
                        end
                        if (fill_fire) begin
                            state_q <= fetch_pkg::fetch_miss_wait;
                        end
                    end
                    fetch_pkg::fetch_miss_wait: begin
                        if (line_valid_i) begin
                            state_q <= fetch_pkg::fetch_run;
                        end
                    end
                    fetch_pkg::fetch_redirect_drain: begin
                        // new pc may still hit the old line meanwhile
                        if (enq_fire) begin
                            pc_q    <= pc_q + fetch_pkg::PC_W'(4);
                            order_q <= order_q + fetch_pkg::ORDER_W'(1);
                        end
                        if (line_valid_i) begin
                            state_q <= fetch_pkg::fetch_run;
                        end
                    end
                    default: begin
                        state_q <= fetch_pkg::fetch_run;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == fetch_pkg::fetch_run && !redirect_valid_i && !hit_i && !fill_valid_q) begin
            fill_addr_q <= {pc_q[fetch_pkg::PC_W-1:bmem_pkg::LINE_OFFSET_W],
                            {bmem_pkg::LINE_OFFSET_W{1'b0}}};
        end
    end

    assign pc_o         = pc_q;
    assign fill_valid_o = fill_valid_q;
    assign fill_addr_o  = fill_addr_q;
    assign flush_o      = redirect_valid_i;

    assign enq_valid_o = hit_i && (state_q != fetch_pkg::fetch_miss_wait) && !redirect_valid_i;
    assign enq_pc_o    = pc_q;
    assign enq_inst_o  = word_i;
    assign enq_order_o = order_q;

endmodule : fetch_ctrl

/* source/inst_queue.sv */
`timescale 1ns/10ps

module inst_queue (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush_i,

    input  logic                          enq_valid_i,
    input  logic [fetch_pkg::PC_W-1:0]    enq_pc_i,
    input  logic [fetch_pkg::INST_W-1:0]  enq_inst_i,
    input  logic [fetch_pkg::ORDER_W-1:0] enq_order_i,
    output logic                          enq_ready_o,

    output logic                          inst_valid_o,
    input  logic                          inst_ready_i,
    output logic [fetch_pkg::INST_W-1:0]  inst_o,
    output logic [fetch_pkg::PC_W-1:0]    inst_pc_o,
    output logic [fetch_pkg::ORDER_W-1:0] inst_order_o,
    output logic                          deq_o
);

    logic [fetch_pkg::PC_W-1:0]        pc_mem    [fetch_pkg::QUEUE_DEPTH];
    logic [fetch_pkg::INST_W-1:0]      inst_mem  [fetch_pkg::QUEUE_DEPTH];
    logic [fetch_pkg::ORDER_W-1:0]     order_mem [fetch_pkg::QUEUE_DEPTH];

    logic [fetch_pkg::QUEUE_PTR_W-1:0] wr_ptr_q;
    logic [fetch_pkg::QUEUE_PTR_W-1:0] rd_ptr_q;
    logic [fetch_pkg::QUEUE_PTR_W:0]   count_q;
    logic                              enq_fire;

    assign enq_ready_o  = (count_q != (fetch_pkg::QUEUE_PTR_W+1)'(fetch_pkg::QUEUE_DEPTH));
    assign inst_valid_o = (count_q != '0);
    assign enq_fire     = enq_valid_i && enq_ready_o;
    assign deq_o        = inst_valid_o && inst_ready_i;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr_q <= wr_ptr_q + fetch_pkg::QUEUE_PTR_W'(1);
            end
            if (deq_o) begin
                rd_ptr_q <= rd_ptr_q + fetch_pkg::QUEUE_PTR_W'(1);
            end
            case ({enq_fire, deq_o})
                2'b10:   count_q <= count_q + (fetch_pkg::QUEUE_PTR_W+1)'(1);
                2'b01:   count_q <= count_q - (fetch_pkg::QUEUE_PTR_W+1)'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            pc_mem[wr_ptr_q]    <= enq_pc_i;
            inst_mem[wr_ptr_q]  <= enq_inst_i;
            order_mem[wr_ptr_q] <= enq_order_i;
        end
    end

    // head read straight from storage
    assign inst_o       = inst_mem[rd_ptr_q];
    assign inst_pc_o    = pc_mem[rd_ptr_q];
    assign inst_order_o = order_mem[rd_ptr_q];

endmodule : inst_queue

/* source/fetch_frontend.sv */
`timescale 1ns/10ps

module fetch_frontend (
    input  logic                             clk,
    input  logic                             rst,

    output logic [bmem_pkg::BMEM_ADDR_W-1:0] bmem_addr_o,
    output logic                             bmem_read_o,
    input  logic                             bmem_ready_i,
    input  logic [bmem_pkg::BMEM_DATA_W-1:0] bmem_rdata_i,
    input  logic                             bmem_rvalid_i,

    input  logic                             redirect_valid_i,
    input  logic [fetch_pkg::PC_W-1:0]       redirect_pc_i,

    output logic                             inst_valid_o,
    input  logic                             inst_ready_i,
    output logic [fetch_pkg::INST_W-1:0]     inst_o,
    output logic [fetch_pkg::PC_W-1:0]       inst_pc_o,
    output logic [fetch_pkg::ORDER_W-1:0]    inst_order_o
);

    // fill request
    logic                             fill_valid;
    logic [bmem_pkg::BMEM_ADDR_W-1:0] fill_addr;
    logic                             fill_ready;

    // returned line
    logic                             line_valid;
    logic [bmem_pkg::LINE_W-1:0]      line_data;
    logic [bmem_pkg::BMEM_ADDR_W-1:0] line_addr;

    logic [fetch_pkg::PC_W-1:0]       pc;
    logic                             hit;
    logic [fetch_pkg::INST_W-1:0]     word;

    logic                             enq_valid;
    logic [fetch_pkg::PC_W-1:0]       enq_pc;
    logic [fetch_pkg::INST_W-1:0]     enq_inst;
    logic [fetch_pkg::ORDER_W-1:0]    enq_order;
    logic                             enq_ready;
    logic                             deq;
    logic                             flush;

    line_fill i_line_fill (
        .clk           (clk),
        .rst           (rst),
        .fill_valid_i  (fill_valid),
        .fill_addr_i   (fill_addr),
        .fill_ready_o  (fill_ready),
        .line_valid_o  (line_valid),
        .line_data_o   (line_data),
        .line_addr_o   (line_addr),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

    line_buffer i_line_buffer (
        .clk          (clk),
        .rst          (rst),
        .line_valid_i (line_valid),
        .line_data_i  (line_data),
        .line_addr_i  (line_addr),
        .pc_i         (pc),
        .hit_o        (hit),
        .word_o       (word)
    );

    fetch_ctrl i_fetch_ctrl (
        .clk              (clk),
        .rst              (rst),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .hit_i            (hit),
        .word_i           (word),
        .pc_o             (pc),
        .fill_valid_o     (fill_valid),
        .fill_addr_o      (fill_addr),
        .fill_ready_i     (fill_ready),
        .line_valid_i     (line_valid),
        .enq_valid_o      (enq_valid),
        .enq_pc_o         (enq_pc),
        .enq_inst_o       (enq_inst),
        .enq_order_o      (enq_order),
        .enq_ready_i      (enq_ready),
        .deq_i            (deq),
        .flush_o          (flush)
    );

    inst_queue i_inst_queue (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush),
        .enq_valid_i  (enq_valid),
        .enq_pc_i     (enq_pc),
        .enq_inst_i   (enq_inst),
        .enq_order_i  (enq_order),
        .enq_ready_o  (enq_ready),
        .inst_valid_o (inst_valid_o),
        .inst_ready_i (inst_ready_i),
        .inst_o       (inst_o),
        .inst_pc_o    (inst_pc_o),
        .inst_order_o (inst_order_o),
        .deq_o        (deq)
    );

endmodule : fetch_frontend

/* verification/tb_fetch_frontend.sv */
`timescale 1ns/10ps

module tb_fetch_frontend;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_MARGIN = 200;
    localparam int SEED           = 94276;
    localparam logic [31:0] WORD_KEY = 32'h13572468;

    logic                             clk;
    logic                             rst;
    logic [bmem_pkg::BMEM_ADDR_W-1:0] bmem_addr_o;
    logic                             bmem_read_o;
    logic                             bmem_ready_i;
    logic [bmem_pkg::BMEM_DATA_W-1:0] bmem_rdata_i;
    logic                             bmem_rvalid_i;
    logic                             redirect_valid_i;
    logic [fetch_pkg::PC_W-1:0]       redirect_pc_i;
    logic                             inst_valid_o;
    logic                             inst_ready_i;
    logic [fetch_pkg::INST_W-1:0]     inst_o;
    logic [fetch_pkg::PC_W-1:0]       inst_pc_o;
    logic [fetch_pkg::ORDER_W-1:0]    inst_order_o;

    // segments from the data file
    int                         seg_cycles   [$];
    int                         seg_rate     [$];
    bit                         seg_redirect [$];
    logic [fetch_pkg::PC_W-1:0] seg_target   [$];
    logic [fetch_pkg::PC_W-1:0] seg_first_pc [$];

    logic [fetch_pkg::PC_W-1:0]    exp_pc;
    logic [fetch_pkg::ORDER_W-1:0] hs_count;
    logic [fetch_pkg::PC_W-1:0]    redirect_first_pc;
    bit                            redirect_pending;
    bit                            prev_stall;
    bit                            prev_read_wait;
    logic [fetch_pkg::INST_W-1:0]  prev_inst;
    logic [fetch_pkg::PC_W-1:0]    prev_pc;
    logic [fetch_pkg::ORDER_W-1:0] prev_order;
    logic [bmem_pkg::BMEM_ADDR_W-1:0] prev_bmem_addr;
    int value_errors;
    int other_errors;
    int cycle_count;
    int cycle_limit;

    fetch_frontend i_fetch_frontend (
        .clk              (clk),
        .rst              (rst),
        .bmem_addr_o      (bmem_addr_o),
        .bmem_read_o      (bmem_read_o),
        .bmem_ready_i     (bmem_ready_i),
        .bmem_rdata_i     (bmem_rdata_i),
        .bmem_rvalid_i    (bmem_rvalid_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .inst_valid_o     (inst_valid_o),
        .inst_ready_i     (inst_ready_i),
        .inst_o           (inst_o),
        .inst_pc_o        (inst_pc_o),
        .inst_order_o     (inst_order_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    // memory content is a fixed function of the byte address
    function automatic logic [31:0] mem_word(logic [31:0] addr);
        return addr ^ WORD_KEY;
    endfunction

    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic report_mismatch(string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        value_errors++;
    endtask

    task automatic report_failure(string msg);
        $display("error at %0t: %s", $time, msg);
        other_errors++;
    endtask

    task automatic print_error_counts();
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    endtask

    task automatic serve_memory();
        logic [31:0] base;
        logic [31:0] beat_addr;
        int          delay;
        int          beat;
        forever begin
            step_cycle();
            if (!rst && bmem_read_o && ($urandom % 100) < 40) begin
                bmem_ready_i = 1'b1;
                base = bmem_addr_o;
                step_cycle();
                bmem_ready_i = 1'b0;
                delay = 1 + $urandom % 8;
                repeat (delay - 1) step_cycle();
                for (beat = 0; beat < bmem_pkg::BEATS_PER_LINE; beat++) begin
                    beat_addr     = base + 32'(8 * beat);
                    bmem_rvalid_i = 1'b1;
                    bmem_rdata_i  = {mem_word(beat_addr + 32'd4), mem_word(beat_addr)};
                    step_cycle();
                    bmem_rvalid_i = 1'b0;
                    repeat ($urandom % 3) step_cycle();
                end
            end
        end
    endtask

    task automatic check_delivery();
        assert (inst_o == mem_word(inst_pc_o))
        else report_mismatch($sformatf("inst %h at pc %h, want %h", inst_o, inst_pc_o,
                                       mem_word(inst_pc_o)));
        assert (inst_pc_o == exp_pc)
        else report_mismatch($sformatf("pc %h, want %h", inst_pc_o, exp_pc));
        // order is the number of earlier handshakes
        assert (inst_order_o == hs_count)
        else report_mismatch($sformatf("order %0d at pc %h, want %0d", inst_order_o,
                                       inst_pc_o, hs_count));
        exp_pc           = exp_pc + 32'd4;
        hs_count         = hs_count + 64'd1;
        redirect_pending = 1'b0;
    endtask

    always @(negedge clk) begin
        if (rst) begin
            prev_stall     = 1'b0;
            prev_read_wait = 1'b0;
        end else begin
            if (prev_stall) begin
                assert (inst_valid_o && inst_o == prev_inst && inst_pc_o == prev_pc &&
                        inst_order_o == prev_order)
                else report_mismatch($sformatf("stalled entry at pc %h did not hold", prev_pc));
            end
            if (prev_read_wait) begin
                assert (bmem_read_o && bmem_addr_o == prev_bmem_addr)
                else report_mismatch($sformatf("read of %h changed before acceptance",
                                               prev_bmem_addr));
            end
            if (bmem_read_o) begin
                assert (bmem_addr_o[bmem_pkg::LINE_OFFSET_W-1:0] == '0)
                else report_mismatch($sformatf("read address %h not line aligned", bmem_addr_o));
            end
            if (inst_valid_o && inst_ready_i) begin
                check_delivery();
            end
            // handshake above still belonged to the old stream
            if (redirect_valid_i) begin
                exp_pc           = redirect_first_pc;
                redirect_pending = 1'b1;
            end
            prev_stall     = inst_valid_o && !inst_ready_i && !redirect_valid_i;
            prev_inst      = inst_o;
            prev_pc        = inst_pc_o;
            prev_order     = inst_order_o;
            prev_read_wait = bmem_read_o && !bmem_ready_i;
            prev_bmem_addr = bmem_addr_o;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            report_failure($sformatf("run did not finish within %0d cycles", cycle_limit));
            print_error_counts();
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin : stimulus
        int                         fd;
        string                      text;
        int                         n;
        int                         cyc;
        int                         rate;
        int                         total;
        int                         c;
        bit                         have_pc;
        logic [fetch_pkg::PC_W-1:0] tgt;
        logic [fetch_pkg::PC_W-1:0] first;
        void'($urandom(SEED));
        rst               = 1'b1;
        inst_ready_i      = 1'b0;
        redirect_valid_i  = 1'b0;
        redirect_pc_i     = '0;
        bmem_ready_i      = 1'b0;
        bmem_rvalid_i     = 1'b0;
        bmem_rdata_i      = '0;
        value_errors      = 0;
        other_errors      = 0;
        cycle_count       = 0;
        cycle_limit       = 0;
        hs_count          = '0;
        redirect_pending  = 1'b0;
        redirect_first_pc = '0;
        have_pc           = 1'b0;
        total             = 0;
        fd = $fopen("verification/fetch_input.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open verification/fetch_input.txt");
        end else begin
            while ($fgets(text, fd) != 0) begin
                if (!have_pc) begin
                    if ($sscanf(text, "%h", tgt) == 1) begin
                        exp_pc  = tgt;
                        have_pc = 1'b1;
                    end
                end else begin
                    n = $sscanf(text, "%d %d %h %h", cyc, rate, tgt, first);
                    if (n >= 2) begin
                        seg_cycles.push_back(cyc);
                        seg_rate.push_back(rate);
                        seg_redirect.push_back(n == 4);
                        seg_target.push_back(tgt);
                        seg_first_pc.push_back(first);
                        total += cyc;
                    end
                end
            end
            $fclose(fd);
        end
        cycle_limit = total + TIMEOUT_MARGIN;
        fork
            serve_memory();
        join_none
        repeat (RESET_CYCLES) step_cycle();
        rst = 1'b0;
        foreach (seg_cycles[s]) begin
            for (c = 0; c < seg_cycles[s]; c++) begin
                inst_ready_i = ($urandom % 100) < seg_rate[s];
                if (c == 0 && seg_redirect[s]) begin
                    redirect_valid_i  = 1'b1;
                    redirect_pc_i     = seg_target[s];
                    redirect_first_pc = seg_first_pc[s];
                end else begin
                    redirect_valid_i = 1'b0;
                end
                step_cycle();
            end
        end
        redirect_valid_i = 1'b0;
        inst_ready_i     = 1'b0;
        step_cycle();
        assert (have_pc) else report_failure("data file holds no reset pc");
        assert (hs_count != 0) else report_failure("no instruction was delivered");
        assert (!redirect_pending)
        else report_failure("no instruction was delivered after the last redirect");
        print_error_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_fetch_frontend

/* verification/fetch_input.txt */
# first value: reset pc (hex)
# then one segment per line: cycles, ready percent, [redirect target, expected first pc] (hex)
aaaaa000
120 100
80 50
# long stall with a full queue
160 0
60 100
90 30
50 100 aaaaa008 aaaaa008
70 75
40 100 aaaab01c aaaab01c
# second redirect lands while the first fill is still out
4 100 aaac0000 aaac0000
60 100 aaac0104 aaac0104
30 0 aaaa0ff8 aaaa0ff8
100 90
30 60 aaaa0ffc aaaa0ffc
120 100
200 40

/* vlog.f */
source/bmem_pkg.sv
source/fetch_pkg.sv
source/line_fill.sv
source/line_buffer.sv
source/fetch_ctrl.sv
source/inst_queue.sv
source/fetch_frontend.sv
verification/tb_fetch_frontend.sv

/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - target: rtl
    files:
      - source/bmem_pkg.sv
      - source/fetch_pkg.sv
      - source/line_fill.sv
      - source/line_buffer.sv
      - source/fetch_ctrl.sv
      - source/inst_queue.sv
      - source/fetch_frontend.sv
  - target: verification
    files:
      - verification/tb_fetch_frontend.sv
